//--- Makefile
# Verilator build and run of the data region testbench

SIM      := verilator
TOP      := data_region_tb
FLIST    := data_region.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := All checks passed
SRCS     := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/data_region_tb.sv
/* data_region_tb
   drives the core, slave and external ports of the data region and checks
   the responses against a reference model of the 64-bit data RAM */

`timescale 1ns/1ps
`default_nettype none

`include "region_cfg.svh"

module data_region_tb;

  localparam int unsigned WAIT_LIMIT = 50;

  logic        clk;
  logic        rst_n;
  logic        lsu_req_i;
  logic [31:0] lsu_addr_i;
  logic        lsu_we_i;
  logic [3:0]  lsu_be_i;
  logic [31:0] lsu_wdata_i;
  logic        lsu_gnt_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_rdata_o;
  logic        ext_req_o;
  logic [31:0] ext_addr_o;
  logic        ext_we_o;
  logic [3:0]  ext_be_o;
  logic [31:0] ext_wdata_o;
  logic        ext_gnt_i;
  logic        ext_rvalid_i;
  logic [31:0] ext_rdata_i;
  logic        slv_req_i;
  logic [31:0] slv_addr_i;
  logic        slv_we_i;
  logic [7:0]  slv_be_i;
  logic [63:0] slv_wdata_i;
  logic [63:0] slv_rdata_o;

  // reference RAM and the bytes written so far
  logic [63:0] ref_mem [512];
  logic [7:0]  ref_wr  [512];
  logic [31:0] ext_last_rdata;
  string       test_name;
  int          checks;
  int          errors;

  tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  data_region DUT (.*);

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("test %s: %s", test_name, msg);
    end
  endtask

  task automatic abort_run(input string msg);
    errors++;
    $display("test %s: timeout, %s", test_name, msg);
    $display("Checks failed");
    $finish;
  endtask

  function automatic logic [31:0] local_addr(input logic [8:0] idx, input logic half);
    return {`REGION_LOCAL_PREFIX, 8'h00, idx, half, 2'b00};
  endfunction

  function automatic logic [63:0] byte_mask(input logic [7:0] flags);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{flags[b]}};
    end
    return m;
  endfunction

  task automatic model_write(input logic [8:0] idx, input logic [7:0] be, input logic [63:0] d);
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        ref_mem[idx][8*b +: 8] = d[8*b +: 8];
        ref_wr[idx][b] = 1'b1;
      end
    end
  endtask

  // a narrow write lands in the half picked by address bit 2
  task automatic model_core_write(input logic [8:0] idx, input logic half,
                                  input logic [3:0] be, input logic [31:0] d);
    model_write(idx, half ? {be, 4'h0} : {4'h0, be}, {d, d});
  endtask

  task automatic check_core_read(input logic [8:0] idx, input logic half, input logic [31:0] act);
    logic [63:0] m;
    logic [63:0] e;
    m = byte_mask(ref_wr[idx]);
    e = ref_mem[idx];
    if (half) begin
      check_val("core read data", 64'(e[63:32] & m[63:32]), 64'(act & m[63:32]));
    end else begin
      check_val("core read data", 64'(e[31:0] & m[31:0]), 64'(act & m[31:0]));
    end
  endtask

  // starts and ends 1 ns after a rising edge and samples at 2 ns
  task automatic core_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int  waited;
    logic is_local;
    is_local    = (addr[31:20] == `REGION_LOCAL_PREFIX);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    waited = 0;
    #1;
    while (!lsu_gnt_o) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("no grant on the core port");
      @(posedge clk);
      #2;
    end
    if (is_local) check_true(!ext_req_o, "local request raised ext_req_o");
    @(posedge clk);
    #1;
    lsu_req_i = 1'b0;
    waited = 0;
    #1;
    while (!lsu_rvalid_o) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("no rvalid on the core port");
      @(posedge clk);
      #2;
    end
    rdata = lsu_rdata_o;
    // local RAM answers in the cycle after acceptance
    if (is_local) check_val("rvalid latency", 64'(0), 64'(waited));
    @(posedge clk);
    #1;
  endtask

  task automatic slave_access(input logic [31:0] addr, input logic we, input logic [7:0] be,
                              input logic [63:0] wdata, output logic [63:0] rdata);
    slv_req_i   = 1'b1;
    slv_addr_i  = addr;
    slv_we_i    = we;
    slv_be_i    = be;
    slv_wdata_i = wdata;
    @(posedge clk);
    #1;
    slv_req_i = 1'b0;
    slv_we_i  = 1'b0;
    #1;
    rdata = slv_rdata_o;
    @(posedge clk);
    #1;
  endtask

  // slave reads for n cycles while the core stays blocked
  task automatic slave_busy(input int n, input logic [31:0] addr);
    slv_req_i  = 1'b1;
    slv_we_i   = 1'b0;
    slv_addr_i = addr;
    repeat (n) begin
      #1;
      check_true(!lsu_gnt_o, "core granted while the slave port was busy");
      @(posedge clk);
      #1;
    end
    slv_req_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
  endtask

  task automatic end_test(input int c0, input int e0);
    $display("test %s: %0d checks, %0d errors", test_name, checks - c0, errors - e0);
  endtask

  // external bus model with random grant and response delays
  initial begin : ext_responder
    int unsigned gd;
    int unsigned rd;
    ext_gnt_i      = 1'b0;
    ext_rvalid_i   = 1'b0;
    ext_rdata_i    = '0;
    ext_last_rdata = '0;
    forever begin
      @(negedge clk);
      if (rst_n && ext_req_o) begin
        check_true(lsu_addr_i[31:20] != `REGION_LOCAL_PREFIX,
                   "ext_req_o raised for local address");
        check_val("ext_addr", 64'(lsu_addr_i), 64'(ext_addr_o));
        check_val("ext_we", 64'(lsu_we_i), 64'(ext_we_o));
        check_val("ext_be", 64'(lsu_be_i), 64'(ext_be_o));
        check_val("ext_wdata", 64'(lsu_wdata_i), 64'(ext_wdata_o));
        gd = $urandom_range(3, 0);
        rd = $urandom_range(3, 1);
        @(posedge clk);
        #1;
        repeat (gd) begin
          @(posedge clk);
          #1;
        end
        ext_gnt_i = 1'b1;
        @(posedge clk);
        #1;
        ext_gnt_i = 1'b0;
        repeat (rd - 1) begin
          @(posedge clk);
          #1;
        end
        ext_rdata_i    = $urandom;
        ext_last_rdata = ext_rdata_i;
        ext_rvalid_i   = 1'b1;
        @(posedge clk);
        #1;
        ext_rvalid_i = 1'b0;
      end
    end
  end

  initial begin : main
    int          c0;
    int          e0;
    int          waited;
    logic [8:0]  idx [16];
    logic        half [16];
    logic [3:0]  be;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] addr;
    logic [63:0] wd64;
    logic [63:0] rd64;
    logic        we;
    void'($urandom(32'h55bb));
    lsu_req_i   = 1'b0;
    lsu_addr_i  = '0;
    lsu_we_i    = 1'b0;
    lsu_be_i    = '0;
    lsu_wdata_i = '0;
    slv_req_i   = 1'b0;
    slv_addr_i  = '0;
    slv_we_i    = 1'b0;
    slv_be_i    = '0;
    slv_wdata_i = '0;
    checks = 0;
    errors = 0;
    test_name = "reset";
    for (int i = 0; i < 512; i++) begin
      ref_mem[i] = '0;
      ref_wr[i]  = '0;
    end
    waited = 0;
    while (rst_n !== 1'b1) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("reset never released");
      @(posedge clk);
    end
    @(posedge clk);
    #1;

    start_test("reset");
    c0 = checks;
    e0 = errors;
    #1;
    check_val("lsu_gnt_o", 64'(0), 64'(lsu_gnt_o));
    check_val("lsu_rvalid_o", 64'(0), 64'(lsu_rvalid_o));
    check_val("ext_req_o", 64'(0), 64'(ext_req_o));
    @(posedge clk);
    #1;
    end_test(c0, e0);

    start_test("core_round_trip");
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      idx[i]  = 9'($urandom);
      half[i] = 1'($urandom);
      be      = 4'($urandom);
      wd      = $urandom;
      core_access(local_addr(idx[i], half[i]), 1'b1, be, wd, rd);
      model_core_write(idx[i], half[i], be, wd);
    end
    for (int i = 0; i < 16; i++) begin
      core_access(local_addr(idx[i], half[i]), 1'b0, 4'hf, 32'h0, rd);
      check_core_read(idx[i], half[i], rd);
    end
    end_test(c0, e0);

    start_test("slave_write_core_read");
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      idx[0] = 9'($urandom);
      wd64   = {$urandom, $urandom};
      slave_access(local_addr(idx[0], 1'b0), 1'b1, 8'hff, wd64, rd64);
      model_write(idx[0], 8'hff, wd64);
      core_access(local_addr(idx[0], 1'b0), 1'b0, 4'hf, 32'h0, rd);
      check_val("lower half", 64'(wd64[31:0]), 64'(rd));
      core_access(local_addr(idx[0], 1'b1), 1'b0, 4'hf, 32'h0, rd);
      check_val("upper half", 64'(wd64[63:32]), 64'(rd));
    end
    end_test(c0, e0);

    start_test("core_write_slave_read");
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      idx[0]  = 9'($urandom);
      half[0] = 1'($urandom);
      be      = 4'($urandom);
      wd      = $urandom;
      core_access(local_addr(idx[0], half[0]), 1'b1, be, wd, rd);
      model_core_write(idx[0], half[0], be, wd);
      slave_access(local_addr(idx[0], 1'b0), 1'b0, 8'h00, 64'h0, rd64);
      check_val("slave read data", ref_mem[idx[0]] & byte_mask(ref_wr[idx[0]]),
                rd64 & byte_mask(ref_wr[idx[0]]));
    end
    end_test(c0, e0);

    start_test("slave_priority");
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      idx[0]  = 9'($urandom);
      half[0] = 1'($urandom);
      wd      = $urandom;
      core_access(local_addr(idx[0], half[0]), 1'b1, 4'hf, wd, rd);
      model_core_write(idx[0], half[0], 4'hf, wd);
      fork
        slave_busy(2 + i, local_addr(9'($urandom), 1'b0));
        core_access(local_addr(idx[0], half[0]), 1'b0, 4'hf, 32'h0, rd);
      join
      check_core_read(idx[0], half[0], rd);
    end
    end_test(c0, e0);

    start_test("external_routing");
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 10; i++) begin
      addr = $urandom;
      if (addr[31:20] == `REGION_LOCAL_PREFIX) begin
        addr[31] = ~addr[31];
      end
      we = 1'($urandom);
      be = 4'($urandom);
      wd = $urandom;
      core_access(addr, we, be, wd, rd);
      if (!we) begin
        check_val("ext read data", 64'(ext_last_rdata), 64'(rd));
      end
    end
    end_test(c0, e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
/* tb_clk_gen
   testbench clock and active-low reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 4,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS/2) clk_o = ~clk_o;
  end

  // release just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- data_region.f
+incdir+src
src/lsu_pkg.sv
src/mem_pkg.sv
src/lsu_router.sv
src/ram_port_arb.sv
src/data_ram.sv
src/data_region.sv
bench/tb_clk_gen.sv
bench/data_region_tb.sv

//--- src/data_ram.sv
/* data_ram
   single-port 64-bit data memory with byte-enable writes and
   registered read data */

`timescale 1ns/1ps
`default_nettype none

`include "region_cfg.svh"

module data_ram (
  input  logic                clk,
  input  logic                en_i,
  input  mem_pkg::ram_addr_t  addr_i,
  input  logic                we_i,
  input  mem_pkg::wide_be_t   be_i,
  input  mem_pkg::wide_word_t wdata_i,
  output mem_pkg::wide_word_t rdata_o
);

  localparam int unsigned DEPTH  = `REGION_RAM_BYTES / (`REGION_WIDE_W/8);
  localparam int unsigned NBYTES = $bits(mem_pkg::wide_be_t);

  mem_pkg::wide_word_t mem_q [DEPTH];

  // byte-lane writes
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read before write on the same row
  always_ff @(posedge clk) begin
    if (en_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- src/data_region.sv
/* data_region
   data-memory region: load/store router, RAM port arbiter and data RAM
   with the core, external bus and slave ports brought out */

`timescale 1ns/1ps
`default_nettype none

module data_region (
  input  logic                  clk,
  input  logic                  rst_n,

  // core load/store port
  input  logic                  lsu_req_i,
  input  lsu_pkg::addr_t        lsu_addr_i,
  input  logic                  lsu_we_i,
  input  lsu_pkg::narrow_be_t   lsu_be_i,
  input  lsu_pkg::narrow_word_t lsu_wdata_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output lsu_pkg::narrow_word_t lsu_rdata_o,

  // external bus
  output logic                  ext_req_o,
  output lsu_pkg::addr_t        ext_addr_o,
  output logic                  ext_we_o,
  output lsu_pkg::narrow_be_t   ext_be_o,
  output lsu_pkg::narrow_word_t ext_wdata_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  lsu_pkg::narrow_word_t ext_rdata_i,

  // 64-bit slave port
  input  logic                  slv_req_i,
  input  lsu_pkg::addr_t        slv_addr_i,
  input  logic                  slv_we_i,
  input  mem_pkg::wide_be_t     slv_be_i,
  input  mem_pkg::wide_word_t   slv_wdata_i,
  output mem_pkg::wide_word_t   slv_rdata_o
);

  // router to arbiter
  logic                  ram_req;
  lsu_pkg::addr_t        ram_addr;
  logic                  ram_we;
  lsu_pkg::narrow_be_t   ram_be;
  lsu_pkg::narrow_word_t ram_wdata;
  logic                  ram_gnt;
  logic                  ram_rvalid;
  lsu_pkg::narrow_word_t ram_rdata;

  // arbiter to RAM
  logic                  mem_en;
  mem_pkg::ram_addr_t    mem_addr;
  logic                  mem_we;
  mem_pkg::wide_be_t     mem_be;
  mem_pkg::wide_word_t   mem_wdata;
  mem_pkg::wide_word_t   mem_rdata;

  lsu_router u_router (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ram_req_o    ( ram_req      ),
    .ram_addr_o   ( ram_addr     ),
    .ram_we_o     ( ram_we       ),
    .ram_be_o     ( ram_be       ),
    .ram_wdata_o  ( ram_wdata    ),
    .ram_gnt_i    ( ram_gnt      ),
    .ram_rvalid_i ( ram_rvalid   ),
    .ram_rdata_i  ( ram_rdata    ),
    .ext_req_o    ( ext_req_o    ),
    .ext_addr_o   ( ext_addr_o   ),
    .ext_we_o     ( ext_we_o     ),
    .ext_be_o     ( ext_be_o     ),
    .ext_wdata_o  ( ext_wdata_o  ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  )
  );

  ram_port_arb u_arb (
    .clk           ( clk         ),
    .rst_n         ( rst_n       ),
    .slv_req_i     ( slv_req_i   ),
    .slv_addr_i    ( slv_addr_i  ),
    .slv_we_i      ( slv_we_i    ),
    .slv_be_i      ( slv_be_i    ),
    .slv_wdata_i   ( slv_wdata_i ),
    .slv_rdata_o   ( slv_rdata_o ),
    .core_req_i    ( ram_req     ),
    .core_addr_i   ( ram_addr    ),
    .core_we_i     ( ram_we      ),
    .core_be_i     ( ram_be      ),
    .core_wdata_i  ( ram_wdata   ),
    .core_gnt_o    ( ram_gnt     ),
    .core_rvalid_o ( ram_rvalid  ),
    .core_rdata_o  ( ram_rdata   ),
    .ram_en_o      ( mem_en      ),
    .ram_addr_o    ( mem_addr    ),
    .ram_we_o      ( mem_we      ),
    .ram_be_o      ( mem_be      ),
    .ram_wdata_o   ( mem_wdata   ),
    .ram_rdata_i   ( mem_rdata   )
  );

  data_ram u_ram (
    .clk     ( clk       ),
    .en_i    ( mem_en    ),
    .addr_i  ( mem_addr  ),
    .we_i    ( mem_we    ),
    .be_i    ( mem_be    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

`default_nettype wire

//--- src/lsu_pkg.sv
/* lsu_pkg
   core-side types of the load/store port */

`default_nettype none

`include "region_cfg.svh"

package lsu_pkg;

  // byte address as issued by the core
  typedef logic [`REGION_ADDR_W-1:0] addr_t;

  // narrow data word and its byte enables
  typedef logic [`REGION_NARROW_W-1:0] narrow_word_t;
  typedef logic [`REGION_NARROW_W/8-1:0] narrow_be_t;

  // path the next response comes back from
  typedef enum logic [0:0] {
    RESP_RAM = 1'b0,
    RESP_EXT = 1'b1
  } resp_src_e;

endpackage

`default_nettype wire

//--- src/lsu_router.sv
/* lsu_router
   decodes the load/store address, sends the request to the data RAM or
   the external bus, and steers the matching response back to the core */

`timescale 1ns/1ps
`default_nettype none

`include "region_cfg.svh"

module lsu_router (
  input  logic                 clk,
  input  logic                 rst_n,

  // core load/store port
  input  logic                 lsu_req_i,
  input  lsu_pkg::addr_t       lsu_addr_i,
  input  logic                 lsu_we_i,
  input  lsu_pkg::narrow_be_t  lsu_be_i,
  input  lsu_pkg::narrow_word_t lsu_wdata_i,
  output logic                 lsu_gnt_o,
  output logic                 lsu_rvalid_o,
  output lsu_pkg::narrow_word_t lsu_rdata_o,

  // local RAM path
  output logic                 ram_req_o,
  output lsu_pkg::addr_t       ram_addr_o,
  output logic                 ram_we_o,
  output lsu_pkg::narrow_be_t  ram_be_o,
  output lsu_pkg::narrow_word_t ram_wdata_o,
  input  logic                 ram_gnt_i,
  input  logic                 ram_rvalid_i,
  input  lsu_pkg::narrow_word_t ram_rdata_i,

  // external bus path
  output logic                 ext_req_o,
  output lsu_pkg::addr_t       ext_addr_o,
  output logic                 ext_we_o,
  output lsu_pkg::narrow_be_t  ext_be_o,
  output lsu_pkg::narrow_word_t ext_wdata_o,
  input  logic                 ext_gnt_i,
  input  logic                 ext_rvalid_i,
  input  lsu_pkg::narrow_word_t ext_rdata_i
);

  logic                is_local;
  lsu_pkg::resp_src_e  resp_src_q;

  // prefix match selects the on-chip RAM
  assign is_local = (lsu_addr_i[`REGION_ADDR_W-1:`REGION_PREFIX_LSB] == `REGION_LOCAL_PREFIX);

  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // payload goes to both paths, only one sees a request
  assign ram_addr_o  = lsu_addr_i;
  assign ram_we_o    = lsu_we_i;
  assign ram_be_o    = lsu_be_i;
  assign ram_wdata_o = lsu_wdata_i;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = (ram_req_o & ram_gnt_i) | (ext_req_o & ext_gnt_i);

  // remember where the accepted request went
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= lsu_pkg::RESP_RAM;
    end else if (lsu_req_i && lsu_gnt_o) begin
      resp_src_q <= is_local ? lsu_pkg::RESP_RAM : lsu_pkg::RESP_EXT;
    end
  end

  // at most one response per path is in flight
  assign lsu_rdata_o  = (resp_src_q == lsu_pkg::RESP_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
/* mem_pkg
   RAM-side types of the 64-bit data memory */

`default_nettype none

`include "region_cfg.svh"

package mem_pkg;

  // one RAM row
  typedef logic [`REGION_WIDE_W-1:0] wide_word_t;

  // byte enables of one row
  typedef logic [`REGION_WIDE_W/8-1:0] wide_be_t;

  // row index, 512 rows for 4 KiB of 8-byte words
  typedef logic [$clog2(`REGION_RAM_BYTES/(`REGION_WIDE_W/8))-1:0] ram_addr_t;

endpackage

`default_nettype wire

//--- src/ram_port_arb.sv
/* ram_port_arb
   shares the data RAM between the 64-bit slave port, which always wins,
   and the 32-bit core port, placing core data in the half chosen by bit 2 */

`timescale 1ns/1ps
`default_nettype none

`include "region_cfg.svh"

module ram_port_arb (
  input  logic                  clk,
  input  logic                  rst_n,

  // slave port, fixed priority, no grant
  input  logic                  slv_req_i,
  input  lsu_pkg::addr_t        slv_addr_i,
  input  logic                  slv_we_i,
  input  mem_pkg::wide_be_t     slv_be_i,
  input  mem_pkg::wide_word_t   slv_wdata_i,
  output mem_pkg::wide_word_t   slv_rdata_o,

  // core port
  input  logic                  core_req_i,
  input  lsu_pkg::addr_t        core_addr_i,
  input  logic                  core_we_i,
  input  lsu_pkg::narrow_be_t   core_be_i,
  input  lsu_pkg::narrow_word_t core_wdata_i,
  output logic                  core_gnt_o,
  output logic                  core_rvalid_o,
  output lsu_pkg::narrow_word_t core_rdata_o,

  // RAM side
  output logic                  ram_en_o,
  output mem_pkg::ram_addr_t    ram_addr_o,
  output logic                  ram_we_o,
  output mem_pkg::wide_be_t     ram_be_o,
  output mem_pkg::wide_word_t   ram_wdata_o,
  input  mem_pkg::wide_word_t   ram_rdata_i
);

  // byte offset bits within a row, and the bit picking the half
  localparam int unsigned OFS_W    = $clog2(`REGION_WIDE_W/8);
  localparam int unsigned IDX_W    = $bits(mem_pkg::ram_addr_t);
  localparam int unsigned HALF_BIT = $clog2(`REGION_NARROW_W/8);
  localparam int unsigned NB       = $bits(lsu_pkg::narrow_be_t);

  logic core_rvalid_q;
  logic half_q;

  assign core_gnt_o = core_req_i & ~slv_req_i;
  assign ram_en_o   = slv_req_i | core_req_i;

  always_comb begin
    if (slv_req_i) begin
      ram_addr_o  = slv_addr_i[OFS_W +: IDX_W];
      ram_we_o    = slv_we_i;
      ram_be_o    = slv_be_i;
      ram_wdata_o = slv_wdata_i;
    end else begin
      ram_addr_o  = core_addr_i[OFS_W +: IDX_W];
      ram_we_o    = core_we_i;
      // narrow enables land in the addressed half
      if (core_addr_i[HALF_BIT]) begin
        ram_be_o = {core_be_i, {NB{1'b0}}};
      end else begin
        ram_be_o = {{NB{1'b0}}, core_be_i};
      end
      // same word in both halves, the enables pick one
      ram_wdata_o = {2{core_wdata_i}};
    end
  end

  // one cycle read latency of the RAM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_q <= 1'b0;
      half_q        <= 1'b0;
    end else begin
      core_rvalid_q <= core_gnt_o;
      if (core_gnt_o) begin
        half_q <= core_addr_i[HALF_BIT];
      end
    end
  end

  assign core_rvalid_o = core_rvalid_q;
  assign core_rdata_o  = half_q ? ram_rdata_i[`REGION_WIDE_W-1 -: `REGION_NARROW_W]
                                : ram_rdata_i[`REGION_NARROW_W-1:0];

  // slave gets the full row
  assign slv_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

//--- src/region_cfg.svh
/* data region configuration
   bus widths, data RAM size and the address prefix of the local window */

`ifndef REGION_CFG_SVH
`define REGION_CFG_SVH

// byte address width on all ports
`define REGION_ADDR_W 32

// load/store port data width
`define REGION_NARROW_W 32

// data RAM and slave port width
`define REGION_WIDE_W 64

// data RAM size in bytes
`define REGION_RAM_BYTES 4096

// address bits 31:20 of the local window
`define REGION_LOCAL_PREFIX 12'h001

// lowest bit of the prefix compare
`define REGION_PREFIX_LSB 20

`endif
